/* compile.f */
hdl/tinker_isa_pkg.sv
hdl/tinker_core_pkg.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/control_fsm.sv
hdl/tinker_core.sv
testbench/tinker_sva.sv
testbench/tinker_tb.sv

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu import tinker_core_pkg::*; import tinker_isa_pkg::*; (
    input  opcode_t opcode,
    input  logic    immediate_form,
    input  word_t   literal,
    input  word_t   rs_val,
    input  word_t   rt_val,
    input  word_t   rd_val,
    input  word_t   pc,
    output word_t   result,
    output addr_t   mem_addr_calc,
    output word_t   store_data,
    output logic    take_branch,
    output word_t   branch_target
);
    word_t op_a;
    word_t op_b;
    word_t load_ea;
    word_t store_ea;

    // register forms use rs and rt
    // immediate forms use rd and the literal
    assign op_a = immediate_form ? rd_val : rs_val;
    assign op_b = immediate_form ? literal : rt_val;

    // effective addresses, truncated to the port width below
    assign load_ea  = rs_val + literal;
    assign store_ea = rd_val + literal;

    assign mem_addr_calc = (opcode == op_store) ? store_ea[31:0] : load_ea[31:0];
    assign store_data    = rs_val;

    // value for rd
    always_comb begin
        result = '0;
        case (opcode)
            op_add, op_addi:     result = op_a + op_b;
            op_sub, op_subi:     result = op_a - op_b;
            // low half of the product only
            op_mul:              result = op_a * op_b;
            op_and:              result = op_a & op_b;
            op_or:               result = op_a | op_b;
            op_xor:              result = op_a ^ op_b;
            op_not:              result = ~rs_val;
            op_shftr, op_shftri: result = op_a >> op_b;
            op_shftl, op_shftli: result = op_a << op_b;
            op_mov:              result = rs_val;
            // keep upper bits of rd
            op_mov_l:            result = {rd_val[63:12], literal[11:0]};
            default:             result = '0;
        endcase
    end

    // branch decision and target
    always_comb begin
        take_branch   = 1'b0;
        branch_target = rd_val;
        case (opcode)
            op_jump: begin
                take_branch = 1'b1;
            end
            op_jump_rel: begin
                take_branch   = 1'b1;
                branch_target = pc + rd_val;
            end
            op_jump_rel2: begin
                take_branch   = 1'b1;
                branch_target = pc + literal;
            end
            op_brnz: begin
                take_branch = (rs_val != '0);
            end
            // signed compare
            op_brgt: begin
                take_branch = ($signed(rs_val) > $signed(rt_val));
            end
            default: begin
                take_branch = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/control_fsm.sv */
`timescale 1ns/10ps

module control_fsm import tinker_core_pkg::*; import tinker_isa_pkg::*; #(
    parameter word_t reset_pc = 64'h0000_0000_0000_2000
) (
    input  logic     clk,
    input  logic     reset,
    input  word_t    mem_rdata,
    output addr_t    mem_addr,
    output word_t    mem_wdata,
    output logic     mem_we,
    output instr_t   instr,
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  word_t    rd_val,
    output word_t    ex_rs_val,
    output word_t    ex_rt_val,
    output word_t    ex_rd_val,
    output word_t    pc,
    input  opcode_t  opcode,
    input  logic     writes_reg,
    input  reg_idx_t rd,
    input  word_t    result,
    input  word_t    store_data,
    input  word_t    branch_target,
    input  addr_t    mem_addr_calc,
    input  logic     take_branch,
    output logic     reg_we,
    output reg_idx_t reg_waddr,
    output word_t    reg_wdata,
    output logic     hlt,
    output state_t   state
);
    // execute results held for mem and writeback
    word_t result_q;
    word_t store_data_q;
    word_t target_q;
    addr_t mem_addr_q;
    logic  take_branch_q;
    word_t load_data_q;

    // sequencer, pc and halt flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
            pc    <= reset_pc;
            hlt   <= 1'b0;
        end else if (!hlt) begin
            case (state)
                st_fetch:   state <= st_decode;
                // halt stops here and the state freezes
                st_decode: begin
                    if (opcode == op_halt) begin
                        hlt <= 1'b1;
                    end else begin
                        state <= st_execute;
                    end
                end
                st_execute: state <= st_mem;
                st_mem:     state <= st_writeback;
                st_writeback: begin
                    state <= st_fetch;
                    pc    <= take_branch_q ? target_q : pc + 64'd4;
                end
                default:    state <= st_fetch;
            endcase
        end
    end

    // stage registers
    always_ff @(posedge clk) begin
        if (state == st_fetch) begin
            instr <= mem_rdata[31:0];
        end
        if (state == st_decode) begin
            ex_rs_val <= rs_val;
            ex_rt_val <= rt_val;
            ex_rd_val <= rd_val;
        end
        if (state == st_execute) begin
            result_q      <= result;
            store_data_q  <= store_data;
            target_q      <= branch_target;
            mem_addr_q    <= mem_addr_calc;
            take_branch_q <= take_branch;
        end
        if (state == st_mem) begin
            load_data_q <= mem_rdata;
        end
    end

    // pc in fetch, data address in mem
    assign mem_addr  = (state == st_mem) ? mem_addr_q : pc[31:0];
    assign mem_wdata = store_data_q;
    assign mem_we    = (state == st_mem) && (opcode == op_store);

    // writeback picks load data or the alu result
    assign reg_we    = (state == st_writeback) && writes_reg;
    assign reg_waddr = rd;
    assign reg_wdata = (opcode == op_load) ? load_data_q : result_q;

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder import tinker_isa_pkg::*; import tinker_core_pkg::*; (
    input  instr_t   instr,
    output opcode_t  opcode,
    output reg_idx_t rd,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output word_t    literal,
    output logic     immediate_form,
    output logic     writes_reg
);
    literal_t lit_field;

    // plain field split
    assign opcode    = instr[op_msb:op_lsb];
    assign rd        = instr[rd_msb:rd_lsb];
    assign rs        = instr[rs_msb:rs_lsb];
    assign rt        = instr[rt_msb:rt_lsb];
    assign lit_field = instr[lit_msb:lit_lsb];

    // sign extension to the full word
    assign literal = {{lit_ext_width{lit_field[11]}}, lit_field};

    // forms that take the literal instead of rt
    always_comb begin
        case (opcode)
            op_addi, op_subi, op_shftri, op_shftli,
            op_mov_l, op_jump_rel2, op_load, op_store: immediate_form = 1'b1;
            default:                                   immediate_form = 1'b0;
        endcase
    end

    // ops that update rd in writeback
    always_comb begin
        case (opcode)
            op_add, op_addi, op_sub, op_subi, op_mul,
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov, op_mov_l, op_load: writes_reg = 1'b1;
            default:                   writes_reg = 1'b0;
        endcase
    end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/10ps

module register_file import tinker_core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t raddr_rs,
    input  reg_idx_t raddr_rt,
    input  reg_idx_t raddr_rd,
    output word_t    rs_val,
    output word_t    rt_val,
    output word_t    rd_val,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);
    word_t regs [num_regs];

    // three independent read ports
    assign rs_val = regs[raddr_rs];
    assign rt_val = regs[raddr_rt];
    assign rd_val = regs[raddr_rd];

    // single write port
    // r0 is an ordinary register here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

/* hdl/tinker_core.sv */
`timescale 1ns/10ps

module tinker_core import tinker_core_pkg::*; import tinker_isa_pkg::*; #(
    parameter word_t reset_pc = 64'h0000_0000_0000_2000
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t mem_rdata,
    output addr_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_we,
    output logic  hlt
);
    // decoded fields of the held instruction
    instr_t   instr;
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    literal;
    logic     immediate_form;
    logic     writes_reg;

    // register reads and latched operands
    word_t rs_val;
    word_t rt_val;
    word_t rd_val;
    word_t ex_rs_val;
    word_t ex_rt_val;
    word_t ex_rd_val;
    word_t pc;

    // alu outputs
    word_t result;
    addr_t mem_addr_calc;
    word_t store_data;
    logic  take_branch;
    word_t branch_target;

    // register write path
    logic     reg_we;
    reg_idx_t reg_waddr;
    word_t    reg_wdata;

    control_fsm #(
        .reset_pc(reset_pc)
    ) i_control_fsm (
        .clk(clk),
        .reset(reset),
        .mem_rdata(mem_rdata),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_we(mem_we),
        .instr(instr),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .rd_val(rd_val),
        .ex_rs_val(ex_rs_val),
        .ex_rt_val(ex_rt_val),
        .ex_rd_val(ex_rd_val),
        .pc(pc),
        .opcode(opcode),
        .writes_reg(writes_reg),
        .rd(rd),
        .result(result),
        .store_data(store_data),
        .branch_target(branch_target),
        .mem_addr_calc(mem_addr_calc),
        .take_branch(take_branch),
        .reg_we(reg_we),
        .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata),
        .hlt(hlt),
        .state()
    );

    instr_decoder i_instr_decoder (
        .instr(instr),
        .opcode(opcode),
        .rd(rd),
        .rs(rs),
        .rt(rt),
        .literal(literal),
        .immediate_form(immediate_form),
        .writes_reg(writes_reg)
    );

    register_file i_register_file (
        .clk(clk),
        .reset(reset),
        .raddr_rs(rs),
        .raddr_rt(rt),
        .raddr_rd(rd),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .rd_val(rd_val),
        .we(reg_we),
        .waddr(reg_waddr),
        .wdata(reg_wdata)
    );

    // alu works on the operands latched in decode
    alu i_alu (
        .opcode(opcode),
        .immediate_form(immediate_form),
        .literal(literal),
        .rs_val(ex_rs_val),
        .rt_val(ex_rt_val),
        .rd_val(ex_rd_val),
        .pc(pc),
        .result(result),
        .mem_addr_calc(mem_addr_calc),
        .store_data(store_data),
        .take_branch(take_branch),
        .branch_target(branch_target)
    );

endmodule

/* hdl/tinker_core_pkg.sv */
package tinker_core_pkg;

    // 64 bit data path
    typedef logic [63:0] word_t;

    // byte address on the memory port
    typedef logic [31:0] addr_t;

    // register index, 32 entries
    typedef logic [4:0] reg_idx_t;

    localparam int num_regs = 32;

    // one state per cycle of an instruction
    typedef enum logic [2:0] {
        st_fetch     = 3'd0,
        st_decode    = 3'd1,
        st_execute   = 3'd2,
        st_mem       = 3'd3,
        st_writeback = 3'd4
    } state_t;

endpackage

/* hdl/tinker_isa_pkg.sv */
package tinker_isa_pkg;

    // raw instruction and its opcode field
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [11:0] literal_t;

    // field positions inside the instruction word
    localparam int op_msb  = 31;
    localparam int op_lsb  = 27;
    localparam int rd_msb  = 26;
    localparam int rd_lsb  = 22;
    localparam int rs_msb  = 21;
    localparam int rs_lsb  = 17;
    localparam int rt_msb  = 16;
    localparam int rt_lsb  = 12;
    localparam int lit_msb = 11;
    localparam int lit_lsb = 0;

    // sign bits added in front of the 12 bit literal
    localparam int lit_ext_width = 52;

    // integer arithmetic
    localparam opcode_t op_add      = 5'b11000;
    localparam opcode_t op_addi     = 5'b11001;
    localparam opcode_t op_sub      = 5'b11010;
    localparam opcode_t op_subi     = 5'b11011;
    localparam opcode_t op_mul      = 5'b11100;
    // logic and shifts
    localparam opcode_t op_and      = 5'b00000;
    localparam opcode_t op_or       = 5'b00001;
    localparam opcode_t op_xor      = 5'b00010;
    localparam opcode_t op_not      = 5'b00011;
    localparam opcode_t op_shftr    = 5'b00100;
    localparam opcode_t op_shftri   = 5'b00101;
    localparam opcode_t op_shftl    = 5'b00110;
    localparam opcode_t op_shftli   = 5'b00111;
    // data movement
    localparam opcode_t op_load     = 5'b10000;
    localparam opcode_t op_mov      = 5'b10001;
    localparam opcode_t op_mov_l    = 5'b10010;
    localparam opcode_t op_store    = 5'b10011;
    // control
    localparam opcode_t op_jump     = 5'b01000;
    localparam opcode_t op_jump_rel = 5'b01001;
    localparam opcode_t op_jump_rel2 = 5'b01010;
    localparam opcode_t op_brnz     = 5'b01011;
    localparam opcode_t op_brgt     = 5'b01110;
    localparam opcode_t op_halt     = 5'b01111;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the Tinker core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tinker_tb \
    -Mdir obj_dir -o tinker_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tinker_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

/* testbench/tinker_sva.sv */
`timescale 1ns/10ps

module tinker_sva import tinker_core_pkg::*; (
    input logic   clk,
    input logic   reset,
    input state_t state,
    input logic   mem_we,
    input logic   hlt
);
    // write strobe only in the memory state
    we_in_mem: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> state == st_mem) else $error("mem_we high outside st_mem");

    // fixed state order while running
    fetch_next: assert property (@(posedge clk) disable iff (reset)
        (!hlt && state == st_fetch) |=> state == st_decode) else $error("bad state after fetch");
    // halt leaves the state in decode
    decode_next: assert property (@(posedge clk) disable iff (reset)
        (!hlt && state == st_decode) |=> (state == st_execute || (hlt && state == st_decode)))
        else $error("bad state after decode");
    execute_next: assert property (@(posedge clk) disable iff (reset)
        (!hlt && state == st_execute) |=> state == st_mem) else $error("bad state after execute");
    mem_next: assert property (@(posedge clk) disable iff (reset)
        (!hlt && state == st_mem) |=> state == st_writeback) else $error("bad state after mem");
    wb_next: assert property (@(posedge clk) disable iff (reset)
        (!hlt && state == st_writeback) |=> state == st_fetch) else $error("bad state after wb");

    // halt is sticky and silent
    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        hlt |=> (hlt && !mem_we)) else $error("hlt dropped or mem_we rose after halt");

endmodule

bind control_fsm tinker_sva i_tinker_sva (
    .clk(clk),
    .reset(reset),
    .state(state),
    .mem_we(mem_we),
    .hlt(hlt)
);

/* testbench/tinker_tb.sv */
`timescale 1ns/10ps

module tinker_tb import tinker_isa_pkg::*; import tinker_core_pkg::*; ();

    localparam word_t reset_pc = 64'h0000_0000_0000_2000;
    localparam int mem_bytes = 65536;
    // ops used by the random arithmetic programs
    localparam opcode_t arith_ops [15] = '{op_add, op_addi, op_sub, op_subi, op_mul,
        op_and, op_or, op_xor, op_not, op_shftr, op_shftri, op_shftl, op_shftli,
        op_mov, op_mov_l};

    logic  clk;
    logic  reset;
    word_t mem_rdata;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_we;
    logic  hlt;

    // DUT memory and the model's private copy
    logic [7:0] mem [mem_bytes];
    logic [7:0] model_mem [mem_bytes];

    instr_t prog [$];
    addr_t  exp_addr [$];
    word_t  exp_data [$];
    addr_t  got_addr [$];
    word_t  got_data [$];
    word_t  mregs [num_regs];
    int     model_count;
    logic [31:0] rng = 32'h091e_4cab;
    int errors = 0;
    int test_errors;
    int tests = 0;
    int failed_tests = 0;

    tinker_core #(
        .reset_pc(reset_pc)
    ) i_tinker_core (
        .clk(clk),
        .reset(reset),
        .mem_rdata(mem_rdata),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_we(mem_we),
        .hlt(hlt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // little endian read
    // addresses wrap inside 64 KiB
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            mem_rdata[8*i +: 8] = mem[16'(mem_addr + 32'(i))];
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t model_read(addr_t a);
        word_t d;
        for (int i = 0; i < 8; i++) begin
            d[8*i +: 8] = model_mem[16'(a + 32'(i))];
        end
        return d;
    endfunction

    task automatic model_write(addr_t a, word_t d);
        for (int i = 0; i < 8; i++) begin
            model_mem[16'(a + 32'(i))] = d[8*i +: 8];
        end
    endtask

    task automatic note_error();
        test_errors++;
        errors++;
    endtask

    // advance one cycle
    // stores are captured at the falling edge
    task automatic tick();
        @(negedge clk);
        if (mem_we) begin
            for (int i = 0; i < 8; i++) begin
                mem[16'(mem_addr + 32'(i))] = mem_wdata[8*i +: 8];
            end
            got_addr.push_back(mem_addr);
            got_data.push_back(mem_wdata);
        end
    endtask

    task automatic emit(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                        logic [11:0] lit);
        prog.push_back({op, rd, rs, rt, lit});
    endtask

    // r30 is the data base 0x8000
    // r29 holds reset_pc
    task automatic prologue();
        prog.delete();
        emit(op_mov_l, 5'd30, 5'd0, 5'd0, 12'h400);
        emit(op_shftli, 5'd30, 5'd0, 5'd0, 12'd5);
        emit(op_mov_l, 5'd29, 5'd0, 5'd0, 12'(reset_pc >> 4));
        emit(op_shftli, 5'd29, 5'd0, 5'd0, 12'd4);
    endtask

    task automatic random_arith(int count);
        for (int i = 0; i < count; i++) begin
            emit(arith_ops[next_rand() % 32'd15], reg_idx_t'(next_rand() % 32'd26),
                 reg_idx_t'(next_rand() % 32'd31), reg_idx_t'(next_rand() % 32'd31),
                 12'(next_rand()));
        end
    endtask

    task automatic gen_arith();
        prologue();
        for (int r = 1; r < 26; r++) begin
            emit(op_mov_l, reg_idx_t'(r), 5'd0, 5'd0, 12'(next_rand()));
        end
        random_arith(40);
        // dump every register
        for (int r = 0; r < 32; r++) begin
            emit(op_store, 5'd30, reg_idx_t'(r), 5'd0, 12'(8 * r));
        end
        emit(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
    endtask

    task automatic gen_ldst();
        logic [11:0] off [11];
        prologue();
        for (int i = 1; i <= 10; i++) begin
            emit(op_mov_l, reg_idx_t'(i), 5'd0, 5'd0, 12'(next_rand()));
            emit(op_shftli, reg_idx_t'(i), 5'd0, 5'd0, 12'(next_rand() % 32'd52));
            emit(op_mov_l, reg_idx_t'(i), 5'd0, 5'd0, 12'(next_rand()));
            // unaligned offsets too
            off[i] = 12'(next_rand() % 32'd900);
            emit(op_store, 5'd30, reg_idx_t'(i), 5'd0, off[i]);
        end
        for (int i = 1; i <= 10; i++) begin
            emit(op_load, reg_idx_t'(10 + i), 5'd30, 5'd0, off[i]);
        end
        for (int i = 1; i <= 10; i++) begin
            emit(op_store, 5'd30, reg_idx_t'(10 + i), 5'd0, 12'(1024 + 8 * i));
        end
        emit(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
    endtask

    task automatic gen_ctrl();
        int kind;
        int skip;
        int m;
        word_t b_addr;
        word_t target;
        prologue();
        m = 0;
        for (int blk = 0; blk < 8; blk++) begin
            kind = int'(next_rand() % 32'd5);
            skip = 1 + int'(next_rand() % 32'd3);
            // seven setup instructions sit in front of the branch
            b_addr = reset_pc + word_t'(4 * (prog.size() + 7));
            target = b_addr + word_t'(4 * (skip + 1));
            emit(op_xor, 5'd28, 5'd28, 5'd28, 12'd0);
            if (kind == 1) begin
                emit(op_addi, 5'd28, 5'd0, 5'd0, 12'(4 * (skip + 1)));
                emit(op_addi, 5'd28, 5'd0, 5'd0, 12'd0);
            end else begin
                emit(op_addi, 5'd28, 5'd0, 5'd0, 12'(target - reset_pc));
                emit(op_add, 5'd28, 5'd28, 5'd29, 12'd0);
            end
            emit(op_xor, 5'd26, 5'd26, 5'd26, 12'd0);
            emit(op_addi, 5'd26, 5'd0, 5'd0,
                 (next_rand() % 32'd3 == 32'd0) ? 12'd0 : 12'(next_rand()));
            emit(op_xor, 5'd27, 5'd27, 5'd27, 12'd0);
            emit(op_addi, 5'd27, 5'd0, 5'd0, 12'(next_rand()));
            case (kind)
                0: emit(op_jump, 5'd28, 5'd0, 5'd0, 12'd0);
                1: emit(op_jump_rel, 5'd28, 5'd0, 5'd0, 12'd0);
                2: emit(op_jump_rel2, 5'd0, 5'd0, 5'd0, 12'(4 * (skip + 1)));
                3: emit(op_brnz, 5'd28, 5'd26, 5'd0, 12'd0);
                default: emit(op_brgt, 5'd28, 5'd26, 5'd27, 12'd0);
            endcase
            // marker stores at distinct addresses
            for (int s = 0; s < skip; s++) begin
                emit(op_store, 5'd30, 5'd26, 5'd0, 12'(8 * m));
                m++;
            end
        end
        emit(op_store, 5'd30, 5'd29, 5'd0, 12'(8 * m));
        emit(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
    endtask

    task automatic gen_halt();
        prologue();
        random_arith(20);
        emit(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
        // never reached
        emit(op_store, 5'd30, 5'd1, 5'd0, 12'd0);
        emit(op_store, 5'd30, 5'd2, 5'd0, 12'd8);
    endtask

    // ISA reference model runs one instruction per pass
    task automatic run_model();
        word_t pc;
        word_t fetched;
        word_t a;
        word_t b;
        word_t d;
        word_t lit;
        word_t res;
        word_t ea;
        instr_t ins;
        opcode_t op;
        reg_idx_t rd;
        logic wr;
        logic halted;
        for (int r = 0; r < num_regs; r++) begin
            mregs[r] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        pc = reset_pc;
        model_count = 0;
        halted = 1'b0;
        while (!halted && model_count < 2000) begin
            fetched = model_read(pc[31:0]);
            ins = fetched[31:0];
            op  = ins[31:27];
            rd  = ins[26:22];
            a   = mregs[ins[21:17]];
            b   = mregs[ins[16:12]];
            d   = mregs[rd];
            lit = {{52{ins[11]}}, ins[11:0]};
            wr  = 1'b1;
            res = '0;
            model_count++;
            case (op)
                op_add:    res = a + b;
                op_addi:   res = d + lit;
                op_sub:    res = a - b;
                op_subi:   res = d - lit;
                op_mul:    res = a * b;
                op_and:    res = a & b;
                op_or:     res = a | b;
                op_xor:    res = a ^ b;
                op_not:    res = ~a;
                op_shftr:  res = a >> b;
                op_shftri: res = d >> lit;
                op_shftl:  res = a << b;
                op_shftli: res = d << lit;
                op_mov:    res = a;
                op_mov_l:  res = {d[63:12], ins[11:0]};
                op_load: begin
                    ea  = a + lit;
                    res = model_read(ea[31:0]);
                end
                default:   wr = 1'b0;
            endcase
            if (wr) begin
                mregs[rd] = res;
            end
            ea = d + lit;
            if (op == op_store) begin
                model_write(ea[31:0], a);
                exp_addr.push_back(ea[31:0]);
                exp_data.push_back(a);
            end
            // next pc
            if (op == op_halt) begin
                halted = 1'b1;
            end else if (op == op_jump || (op == op_brnz && a != '0) ||
                         (op == op_brgt && $signed(a) > $signed(b))) begin
                pc = d;
            end else if (op == op_jump_rel) begin
                pc = pc + d;
            end else if (op == op_jump_rel2) begin
                pc = pc + lit;
            end else begin
                pc = pc + 64'd4;
            end
        end
    endtask

    task automatic load_memory();
        for (int a = 0; a < mem_bytes; a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8);
            model_mem[a] = 8'(a) ^ 8'(a >> 8);
        end
        for (int i = 0; i < prog.size(); i++) begin
            for (int j = 0; j < 4; j++) begin
                mem[16'(reset_pc + word_t'(4 * i + j))] = prog[i][8*j +: 8];
                model_mem[16'(reset_pc + word_t'(4 * i + j))] = prog[i][8*j +: 8];
            end
        end
    endtask

    task automatic run_program(string name, bit quiet_after_halt);
        int limit;
        int cycles;
        test_errors = 0;
        @(negedge clk);
        reset = 1'b1;
        load_memory();
        run_model();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        got_addr.delete();
        got_data.delete();
        assert (!hlt) else begin
            $display("CHECK FAILED %s hlt after reset expected 0 actual %b", name, hlt);
            note_error();
        end
        assert (!mem_we) else begin
            $display("CHECK FAILED %s mem_we after reset expected 0 actual %b", name, mem_we);
            note_error();
        end
        assert (mem_addr == reset_pc[31:0]) else begin
            $display("CHECK FAILED %s first mem_addr expected %h actual %h",
                     name, reset_pc[31:0], mem_addr);
            note_error();
        end
        assert (model_count < 2000) else begin
            $display("test %s: reference model never reached halt", name);
            note_error();
        end
        limit = model_count * 5 + 10;
        cycles = 0;
        while (!hlt && cycles < limit) begin
            tick();
            cycles++;
        end
        assert (hlt) else begin
            $display("test %s: hlt did not rise within %0d cycles", name, limit);
            note_error();
        end
        assert (got_addr.size() == exp_addr.size()) else begin
            $display("CHECK FAILED %s store count expected %0d actual %0d",
                     name, exp_addr.size(), got_addr.size());
            note_error();
        end
        for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
            assert (got_addr[i] == exp_addr[i] && got_data[i] == exp_data[i]) else begin
                $display("CHECK FAILED %s store %0d expected %h:%h actual %h:%h", name, i,
                         exp_addr[i], exp_data[i], got_addr[i], got_data[i]);
                note_error();
            end
        end
        if (quiet_after_halt) begin
            for (int i = 0; i < 50; i++) begin
                tick();
                assert (hlt && !mem_we) else begin
                    $display("CHECK FAILED %s after halt expected hlt 1 mem_we 0 actual %b %b",
                             name, hlt, mem_we);
                    note_error();
                end
            end
        end
        tests++;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %s: %s (%0d instructions, %0d stores)", name,
                 (test_errors == 0) ? "pass" : "FAIL", model_count, exp_addr.size());
    endtask

    initial begin
        reset = 1'b1;
        prog.delete();
        emit(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program("reset", 1'b0);
        gen_arith();
        run_program("arith_logic", 1'b0);
        gen_ldst();
        run_program("load_store", 1'b0);
        gen_ctrl();
        run_program("control_flow", 1'b0);
        gen_halt();
        run_program("halt", 1'b1);
        $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
